// File: all.f
src/fperm_pkg.sv
src/fperm_lane_move.sv
src/fperm_seed_est.sv
src/fperm_const_table.sv
src/fperm_pipe.sv
src/fperm_top.sv
sim/fperm_tb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and decide from the simulation log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module fperm_tb \
  -Mdir obj_dir -o fperm_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fperm_sim > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/fperm_tb.sv
`default_nettype none

module fperm_tb
  import fperm_pkg::*;
();

  localparam int MAX_CYCLES = 6000;    // Roughly 2400 issue cycles plus gaps, doubled.
  localparam int SEED       = 51;

  // One expected result, as queued at issue.
  typedef struct packed {
    fp_word_t    word;
    fperm_kind_t kind;
    int          due;                  // Cycle count at which res_valid must be seen.
  } exp_entry_t;

  logic      clk;
  logic      rst;
  logic      en;
  fperm_op_t op;
  fp_word_t  a;
  fp_word_t  b;
  fp_word_t  res;
  logic      res_valid;

  fp_word_t   shadow [TBL_DEPTH];      // Mirror of the DUT table contents.
  exp_entry_t exp_q [$];
  int         cyc;
  int         checks;
  int         errors;

  fperm_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .op        (op),
    .a         (a),
    .b         (b),
    .res       (res),
    .res_valid (res_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Exponent seed from the rule, worked in plain integers.
  function automatic int seed_exp(input int e, input int bias, input int w, input bit rsqrt);
    int m;
    int v;
    m = 1 << w;
    v = (rsqrt ? 3 : 2) * bias - e;
    v = ((v % m) + m) % m;
    if (rsqrt) begin
      v = v / 2;
    end
    return v;
  endfunction

  function automatic fp_word_t ref_seed(input bit rsqrt, input fp_word_t wa, input fp_word_t wb);
    fp_word_t r;
    r = '0;
    if (wa.dbl.tag == TAG_DBL) begin   // Format is taken from A.
      r.dbl.tag  = wb.dbl.tag;
      r.dbl.sign = wb.dbl.sign;
      r.dbl.exp  = 12'(seed_exp(int'(wb.dbl.exp), int'(BIAS_D), 12, rsqrt));
    end else begin
      r.pair.tag     = wb.pair.tag;
      r.pair.hi.sign = wb.pair.hi.sign;
      r.pair.hi.exp  = 9'(seed_exp(int'(wb.pair.hi.exp), int'(BIAS_S), 9, rsqrt));
      r.pair.lo.sign = wb.pair.lo.sign;
      r.pair.lo.exp  = 9'(seed_exp(int'(wb.pair.lo.exp), int'(BIAS_S), 9, rsqrt));
    end
    return r;
  endfunction

  // Expected word for one operation, given the table entry before any write.
  function automatic fp_word_t ref_result(input fperm_op_t o, input fp_word_t wa,
                                          input fp_word_t wb, input fp_word_t old);
    fp_word_t    src;
    logic [32:0] hi;
    logic [32:0] lo;
    logic [32:0] tmp;
    case (o.kind)
      KIND_TBL_READ: return old;
      KIND_RECIP:    return ref_seed(1'b0, wa, wb);
      KIND_RSQRT:    return ref_seed(1'b1, wa, wb);
      default: begin
        src = o.copy_a ? wa : wb;
        hi  = src[65:33];
        lo  = src[32:0];
        if (o.swap_sngl) begin
          tmp = hi;
          hi  = lo;
          lo  = tmp;
        end
        if (o.dup_sngl) begin
          hi = lo;
        end
        return {src[67:66], hi, lo};
      end
    endcase
  endfunction

  function automatic fp_tag_t rand_tag();
    if ($urandom_range(0, 1) == 0) begin
      return TAG_DBL;
    end
    return 2'($urandom_range(1, 3));
  endfunction

  function automatic fp_word_t rand_word(input fp_tag_t tag);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    r0 = $urandom();
    r1 = $urandom();
    r2 = $urandom();
    return {tag, r0, r1, r2[1:0]};
  endfunction

  // Forces exponents to zero or all ones now and then.
  function automatic fp_word_t edge_exps(input fp_word_t w);
    int s;
    s = $urandom_range(0, 3);
    if (w.dbl.tag == TAG_DBL) begin
      if (s == 0) begin
        w.dbl.exp = '0;
      end else if (s == 1) begin
        w.dbl.exp = '1;
      end
    end else if (s == 0) begin
      w.pair.hi.exp = '0;
      w.pair.lo.exp = '1;
    end else if (s == 1) begin
      w.pair.hi.exp = '1;
      w.pair.lo.exp = '0;
    end
    return w;
  endfunction

  // Swap and dup are never requested together.
  function automatic fperm_op_t rand_op(input fperm_kind_t kind);
    fperm_op_t o;
    int        sel;
    o         = '0;
    o.kind    = kind;
    o.copy_a  = ($urandom_range(0, 1) == 1);
    sel       = $urandom_range(0, 2);
    o.swap_sngl = (sel == 1);
    o.dup_sngl  = (sel == 2);
    o.idx     = 3'($urandom_range(0, 7));
    return o;
  endfunction

  task automatic issue(input fperm_op_t o, input fp_word_t wa, input fp_word_t wb);
    exp_entry_t e;
    e.word = ref_result(o, wa, wb, shadow[o.idx]);
    e.kind = o.kind;
    e.due  = cyc + PIPE_LAT;           // Captured at edge cyc + 1, valid from the next edge.
    exp_q.push_back(e);
    if (o.tbl_write) begin
      shadow[o.idx] = wb;
    end
    en = 1'b1;
    op = o;
    a  = wa;
    b  = wb;
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    en = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic drain();
    en = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic clear_shadow();
    for (int i = 0; i < TBL_DEPTH; i++) begin
      shadow[i] = '0;
    end
  endtask

  // Results still due after this cycle are lost to the reset.
  task automatic drop_in_flight();
    exp_entry_t keep [$];
    foreach (exp_q[i]) begin
      if (exp_q[i].due <= cyc) begin
        keep.push_back(exp_q[i]);
      end
    end
    exp_q = keep;
  endtask

  task automatic read_all();
    fperm_op_t o;
    for (int i = 0; i < TBL_DEPTH; i++) begin
      o      = '0;
      o.kind = KIND_TBL_READ;
      o.idx  = 3'(i);
      issue(o, rand_word(rand_tag()), rand_word(rand_tag()));
    end
  endtask

  task automatic report(input string name, input int c0, input int e0);
    $display("Test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  task automatic test_lane_moves();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 400; i++) begin
      issue(rand_op(KIND_MOVE), rand_word(rand_tag()), rand_word(rand_tag()));
    end
    drain();
    report("lane moves", c0, e0);
  endtask

  task automatic test_seeds(input fperm_kind_t kind, input string name);
    fp_tag_t t;
    int      c0;
    int      e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      t = rand_tag();
      issue(rand_op(kind), rand_word(t), edge_exps(rand_word(t)));
    end
    drain();
    report(name, c0, e0);
  endtask

  task automatic test_table();
    fperm_op_t o;
    int        c0;
    int        e0;
    c0 = checks;
    e0 = errors;
    read_all();                        // Nothing written since reset.
    for (int i = 0; i < 150; i++) begin
      o           = rand_op(KIND_TBL_READ);
      o.tbl_write = ($urandom_range(0, 1) == 1);
      issue(o, rand_word(rand_tag()), rand_word(rand_tag()));
    end
    read_all();
    for (int i = 0; i < 50; i++) begin
      o           = rand_op(KIND_TBL_READ);
      o.tbl_write = 1'b1;              // Read sees the entry before this write.
      issue(o, rand_word(rand_tag()), rand_word(rand_tag()));
    end
    read_all();
    drain();
    report("constant table", c0, e0);
  endtask

  task automatic test_stream();
    fperm_op_t o;
    int        c0;
    int        e0;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 800; i++) begin
      if ($urandom_range(0, 3) == 0) begin
        idle($urandom_range(1, 3));
      end
      o           = rand_op(fperm_kind_t'($urandom_range(0, 3)));
      o.tbl_write = ($urandom_range(0, 7) == 0);
      issue(o, rand_word(rand_tag()), rand_word(rand_tag()));
    end
    drain();
    report("back-to-back stream", c0, e0);
  endtask

  task automatic test_reset_midstream();
    fperm_op_t o;
    int        n;
    int        c0;
    int        e0;
    c0 = checks;
    e0 = errors;
    for (int r = 0; r < 4; r++) begin
      n = $urandom_range(5, 20);
      for (int i = 0; i < n; i++) begin
        o           = rand_op(fperm_kind_t'($urandom_range(0, 3)));
        o.tbl_write = ($urandom_range(0, 3) == 0);
        issue(o, rand_word(rand_tag()), rand_word(rand_tag()));
      end
      rst = 1'b1;
      en  = 1'b0;
      drop_in_flight();
      clear_shadow();
      repeat (3) @(negedge clk);
      rst = 1'b0;
      read_all();
      drain();
    end
    report("reset mid-stream", c0, e0);
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk) begin : compare
    exp_entry_t e;
    if (res_valid === 1'b1) begin
      assert (exp_q.size() > 0)
        else begin
          $display("Unexpected res_valid at time %0t with no operation outstanding", $time);
          errors++;
        end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        checks++;
        assert (res === e.word)
          else begin
            $display("ERROR at %0t: %s result %h, expected %h",
                     $time, e.kind.name(), res, e.word);
            errors++;
          end
        assert (cyc == e.due)
          else begin
            $display("ERROR at %0t: result arrived at cycle %0d, expected cycle %0d",
                     $time, cyc, e.due);
            errors++;
          end
      end
    end
  end

  initial begin
    cyc = 0;
    while (cyc < MAX_CYCLES) begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Errors found");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    checks = 0;
    errors = 0;
    rst    = 1'b1;
    en     = 1'b0;
    op     = '0;
    a      = '0;
    b      = '0;
    clear_shadow();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_lane_moves();
    test_seeds(KIND_RECIP, "reciprocal seeds");
    test_seeds(KIND_RSQRT, "reciprocal square root seeds");
    test_table();
    test_stream();
    test_reset_midstream();
    assert (exp_q.size() == 0)
      else begin
        $display("%0d operations never produced res_valid", exp_q.size());
        errors++;
      end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/fperm_const_table.sv
`default_nettype none

module fperm_const_table
  import fperm_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       en,
  input  logic       tbl_write,
  input  logic [2:0] idx,
  input  fp_word_t   b,
  output fp_word_t   tbl_data
);

  fp_word_t mem [TBL_DEPTH];

  // A read in the same operation as a write sees the old entry,
  // since both use the value held before the edge.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TBL_DEPTH; i++) begin
        mem[i] <= '0;
      end
      tbl_data <= '0;
    end else if (en) begin
      if (tbl_write) begin
        mem[idx] <= b;                 // Store B.
      end
      tbl_data <= mem[idx];            // Captured on every enabled edge.
    end
  end

  // An unknown index would corrupt the table or the read path.
  a_idx_known: assert property (@(posedge clk) disable iff (rst) en |-> !$isunknown(idx))
    else $error("fperm_const_table: idx unknown while en is high");

endmodule

`default_nettype wire

// File: src/fperm_lane_move.sv
`default_nettype none

module fperm_lane_move
  import fperm_pkg::*;
(
  input  fp_word_t  a,
  input  fp_word_t  b,
  input  fperm_op_t op,
  output fp_word_t  move_res
);

  fp_word_t src;

  always_comb begin
    src      = op.copy_a ? a : b;      // Operand select.
    move_res = src;
    if (op.swap_sngl) begin
      move_res.pair.hi = src.pair.lo;  // Exchange the halves.
      move_res.pair.lo = src.pair.hi;
    end
    if (op.dup_sngl) begin
      move_res.pair.hi = move_res.pair.lo;  // Tag stays as it was.
    end
  end

  // Swap and duplicate are exclusive requests from the decoder.
  // This block has no clock, so the check runs on every change of op.
  always_comb begin
    assert (!(op.swap_sngl === 1'b1 && op.dup_sngl === 1'b1))
      else $error("fperm_lane_move: swap_sngl and dup_sngl set together");
  end

endmodule

`default_nettype wire

// File: src/fperm_pipe.sv
`default_nettype none

module fperm_pipe
  import fperm_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        en,
  input  fperm_kind_t kind,
  input  fp_word_t    move_res,
  input  fp_word_t    seed_res,
  input  fp_word_t    tbl_data,
  output fp_word_t    res,
  output logic        res_valid
);

  logic [PIPE_LAT-1:0] vld_sr;         // One bit per stage.
  fperm_kind_t         s1_kind;
  fp_word_t            s1_res;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[PIPE_LAT-2:0], en};
    end
  end

  // Stage 1 holds the computed result.
  always_ff @(posedge clk) begin
    if (en) begin
      s1_kind <= kind;
      s1_res  <= (kind == KIND_RECIP || kind == KIND_RSQRT) ? seed_res : move_res;
    end
  end

  // Stage 2 takes the table word, which arrives one cycle after the read.
  always_ff @(posedge clk) begin
    if (vld_sr[0]) begin
      res <= (s1_kind == KIND_TBL_READ) ? tbl_data : s1_res;
    end
  end

  assign res_valid = vld_sr[PIPE_LAT-1];

  // Operations in flight at reset are dropped, so no strobe leaks out.
  a_no_valid_after_rst: assert property (@(posedge clk) $fell(rst) |-> !res_valid [*PIPE_LAT])
    else $error("fperm_pipe: res_valid high right after reset");

endmodule

`default_nettype wire

// File: src/fperm_pkg.sv
`default_nettype none

package fperm_pkg;

  // Type tag in the top two bits of every register word.
  typedef logic [1:0] fp_tag_t;

  localparam fp_tag_t TAG_DBL = 2'b00;     // Any other tag means paired singles.

  // Exponent biases of the extended formats.
  localparam logic [11:0] BIAS_D = 12'd2047;
  localparam logic [8:0]  BIAS_S = 9'd255;

  localparam int TBL_DEPTH = 8;            // Entries in the constant table.
  localparam int PIPE_LAT  = 2;            // Cycles from enable to valid.

  // One extended single, 33 bits.
  typedef struct packed {
    logic        sign;
    logic [8:0]  exp;
    logic [22:0] mant;
  } fp_sngl_t;

  // Word read as one extended double.
  typedef struct packed {
    fp_tag_t     tag;
    logic        sign;
    logic [11:0] exp;
    logic [52:0] mant;
  } fp_dbl_t;

  // Word read as two extended singles.
  typedef struct packed {
    fp_tag_t  tag;
    fp_sngl_t hi;
    fp_sngl_t lo;
  } fp_pair_t;

  // The 68-bit register word.
  // Both views share the same tag bits.
  typedef union packed {
    fp_dbl_t  dbl;
    fp_pair_t pair;
  } fp_word_t;

  typedef enum logic [1:0] {
    KIND_MOVE     = 2'd0,              // Lane move of A or B.
    KIND_RECIP    = 2'd1,              // Reciprocal exponent seed.
    KIND_RSQRT    = 2'd2,              // Reciprocal square root exponent seed.
    KIND_TBL_READ = 2'd3               // Constant table read.
  } fperm_kind_t;

  // Decoded operation as it arrives with the enable strobe.
  typedef struct packed {
    fperm_kind_t kind;
    logic        copy_a;               // Source is A rather than B.
    logic        swap_sngl;            // Exchange the high and low singles.
    logic        dup_sngl;             // Low single goes to both halves.
    logic        tbl_write;            // Store B at idx.
    logic [2:0]  idx;                  // Table entry.
  } fperm_op_t;

endpackage

`default_nettype wire

// File: src/fperm_seed_est.sv
`default_nettype none

module fperm_seed_est
  import fperm_pkg::*;
(
  input  fp_word_t    a,
  input  fp_word_t    b,
  input  fperm_kind_t kind,
  output fp_word_t    seed_res
);

  // Seed constants, already reduced to the field width.
  localparam logic [11:0] RCP_K_D = 12'(2 * BIAS_D);
  localparam logic [11:0] RSQ_K_D = 12'(3 * BIAS_D);
  localparam logic [8:0]  RCP_K_S = 9'(2 * BIAS_S);
  localparam logic [8:0]  RSQ_K_S = 9'(3 * BIAS_S);

  logic is_rsqrt;
  logic is_dbl;

  // Exponent seed of a double.
  function automatic logic [11:0] seed_exp_d(input logic [11:0] e, input logic rsqrt);
    logic [11:0] diff;
    if (rsqrt) begin
      diff = RSQ_K_D - e;              // Wraps modulo 2^12.
      return diff >> 1;                // Halve, fraction dropped.
    end
    diff = RCP_K_D - e;
    return diff;
  endfunction

  // Exponent seed of one single, used for both halves.
  function automatic logic [8:0] seed_exp_s(input logic [8:0] e, input logic rsqrt);
    logic [8:0] diff;
    if (rsqrt) begin
      diff = RSQ_K_S - e;              // Wraps modulo 2^9.
      return diff >> 1;
    end
    diff = RCP_K_S - e;
    return diff;
  endfunction

  assign is_rsqrt = (kind == KIND_RSQRT);   // Reciprocal for every other kind.
  assign is_dbl   = (a.dbl.tag == TAG_DBL); // The format follows A.

  always_comb begin
    seed_res = '0;                     // Mantissas stay zero.
    if (is_dbl) begin
      seed_res.dbl.tag  = b.dbl.tag;
      seed_res.dbl.sign = b.dbl.sign;
      seed_res.dbl.exp  = seed_exp_d(b.dbl.exp, is_rsqrt);
    end else begin
      seed_res.pair.tag     = b.pair.tag;
      seed_res.pair.hi.sign = b.pair.hi.sign;
      seed_res.pair.hi.exp  = seed_exp_s(b.pair.hi.exp, is_rsqrt);
      seed_res.pair.lo.sign = b.pair.lo.sign;
      seed_res.pair.lo.exp  = seed_exp_s(b.pair.lo.exp, is_rsqrt);
    end
  end

endmodule

`default_nettype wire

// File: src/fperm_top.sv
`default_nettype none

module fperm_top
  import fperm_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  fperm_op_t op,
  input  fp_word_t  a,
  input  fp_word_t  b,
  output fp_word_t  res,
  output logic      res_valid
);

  fp_word_t move_res;
  fp_word_t seed_res;
  fp_word_t tbl_data;                  // Valid one cycle after the read.

  fperm_lane_move u_lane_move (
    .a        (a),
    .b        (b),
    .op       (op),
    .move_res (move_res)
  );

  fperm_seed_est u_seed_est (
    .a        (a),
    .b        (b),
    .kind     (op.kind),
    .seed_res (seed_res)
  );

  fperm_const_table u_const_table (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .tbl_write (op.tbl_write),
    .idx       (op.idx),
    .b         (b),
    .tbl_data  (tbl_data)
  );

  fperm_pipe u_pipe (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .kind      (op.kind),
    .move_res  (move_res),
    .seed_res  (seed_res),
    .tbl_data  (tbl_data),
    .res       (res),
    .res_valid (res_valid)
  );

endmodule

`default_nettype wire
